// File: laser_pulser.f
verilog/pulser_timing_pkg.sv
verilog/pulser_ctrl_pkg.sv
verilog/input_debounce.sv
verilog/quadrature_decode.sv
verilog/delay_adjust.sv
verilog/period_sequencer.sv
verilog/pulse_window.sv
verilog/laser_pulser_top.sv
verif/pulser_tb_clock.sv
verif/laser_pulser_tb.sv

// File: Bender.yml
package:
  name: laser_pulser

sources:
  - files:
      - verilog/pulser_timing_pkg.sv
      - verilog/pulser_ctrl_pkg.sv
      - verilog/input_debounce.sv
      - verilog/quadrature_decode.sv
      - verilog/delay_adjust.sv
      - verilog/period_sequencer.sv
      - verilog/pulse_window.sv
      - verilog/laser_pulser_top.sv
  - target: test
    files:
      - verif/pulser_tb_clock.sv
      - verif/laser_pulser_tb.sv

// File: verif/laser_pulser_tb.sv
`timescale 1ns/1ps

module laser_pulser_tb;

	localparam int PERIOD = 200;
	localparam int LASER_WIDTH = 20;
	localparam int TRIG1_DELAY = 40;
	localparam int TRIG2_DELAY = 120;
	localparam int TRIG_WIDTH = 3;
	localparam int STEP = 2;
	localparam int DEBOUNCE = 4;

	localparam int PERIOD_CYCLES = PERIOD + 1;
	localparam int HOLD = DEBOUNCE + 8; // per knob phase, past the debounce
	localparam int DETENT = 4 * (HOLD + 1);
	localparam int CYCLE_PERIODS = 260;

	// worst case length of each test, in cycles
	localparam int LEN_PERIOD = 5 * PERIOD_CYCLES;
	localparam int LEN_DEFAULT = 2 * PERIOD_CYCLES;
	localparam int LEN_KNOB = 2 * (16 * DETENT + 4 * PERIOD_CYCLES);
	localparam int LEN_SATURATE = 130 * DETENT + 2 * (2 * HOLD + 3) + 3 * PERIOD_CYCLES;
	localparam int LEN_ROT = 16 * PERIOD_CYCLES;
	localparam int LEN_CYCLE = (CYCLE_PERIODS + 1) * PERIOD_CYCLES;
	localparam int TIMEOUT_CYCLES = 10 + LEN_PERIOD + LEN_DEFAULT + LEN_KNOB + LEN_SATURATE
		+ LEN_ROT + LEN_CYCLE + 4 * PERIOD_CYCLES;

	logic clock10, reset10;
	logic knob_a, knob_b, knob_push;
	pulser_ctrl_pkg::rot_t rot_n;
	logic laser_trigger, larpix_trigger;
	pulser_timing_pkg::cycle_count_t cycle_count;
	pulser_ctrl_pkg::offset_t delay_offset;

	int count_errors = 0;
	int offset_errors = 0;
	int cycle_errors = 0;
	int other_errors = 0;
	int cycle_no = 0;
	int laser_rises = 0;
	logic laser_seen = 1'b0;
	logic [15:0] lfsr_state;
	int expected_offset;

	// last measured period
	int period_len;
	int laser_high;
	int rise_q[$]; // readout rises, cycles after the laser rise
	int width_q[$];

	pulser_tb_clock i_clock (.clock10(clock10), .reset10(reset10));

	laser_pulser_top #(
		.PERIOD_COUNTS(PERIOD), .LASER_WIDTH(LASER_WIDTH), .TRIG1_DELAY(TRIG1_DELAY),
		.TRIG2_DELAY(TRIG2_DELAY), .TRIG_WIDTH(TRIG_WIDTH), .STEP_COUNTS(STEP),
		.DEBOUNCE_COUNTS(DEBOUNCE)
	) i_laser_pulser_top (
		.clock10(clock10), .reset10(reset10), .knob_a(knob_a), .knob_b(knob_b),
		.knob_push(knob_push), .rot_n(rot_n), .laser_trigger(laser_trigger),
		.larpix_trigger(larpix_trigger), .cycle_count(cycle_count),
		.delay_offset(delay_offset));

	// laser edge count and watchdog
	always @(negedge clock10) begin
		cycle_no++;
		if (laser_trigger === 1'b1 && laser_seen === 1'b0) laser_rises++;
		laser_seen = laser_trigger;
		if (cycle_no >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a test stopped waiting for the DUT", cycle_no);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic int lfsr_bits(input int n);
		int value;
		int i;
		value = 0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
			value = (value << 1) | lfsr_state[0];
		end
		return value;
	endfunction

	task automatic compare_count(input pulser_timing_pkg::count_t got,
		input pulser_timing_pkg::count_t expected, input string what);
		if (got !== expected) begin
			count_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_offset(input pulser_ctrl_pkg::offset_t got,
		input pulser_ctrl_pkg::offset_t expected, input string what);
		if (got !== expected) begin
			offset_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic compare_cycle(input pulser_timing_pkg::cycle_count_t got,
		input pulser_timing_pkg::cycle_count_t expected, input string what);
		if (got !== expected) begin
			cycle_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic wait_laser_rise();
		logic prev;
		do begin
			prev = laser_trigger;
			@(negedge clock10);
		end while (!(laser_trigger === 1'b1 && prev === 1'b0));
	endtask

	// from one laser rise up to the next
	task automatic measure_period();
		int t;
		int run;
		logic lar_prev;
		logic las_prev;
		wait_laser_rise();
		laser_high = 1;
		period_len = 0;
		rise_q.delete();
		width_q.delete();
		lar_prev = larpix_trigger;
		las_prev = 1'b1;
		run = 0;
		for (t = 1; t <= 2 * PERIOD_CYCLES && period_len == 0; t++) begin
			@(negedge clock10);
			if (laser_trigger && !las_prev) period_len = t;
			else if (laser_trigger) laser_high++;
			if (larpix_trigger && !lar_prev) begin
				rise_q.push_back(t);
				run = 0;
			end
			if (larpix_trigger) run++;
			else if (lar_prev) width_q.push_back(run); // pulse just ended
			lar_prev = larpix_trigger;
			las_prev = laser_trigger;
		end
	endtask

	task automatic check_readouts(input int first_delay, input int second_delay);
		measure_period();
		if (rise_q.size() != 2 || width_q.size() != 2) begin
			other_errors++;
			$display("at %0t: expected two readout pulses in the period, saw %0d rises",
				$time, rise_q.size());
		end else begin
			compare_count(rise_q[0], first_delay, "first readout delay");
			compare_count(rise_q[1], second_delay, "second readout delay");
			compare_count(width_q[0], TRIG_WIDTH, "first readout width");
			compare_count(width_q[1], TRIG_WIDTH, "second readout width");
		end
	endtask

	task automatic drive_knob_phase(input logic a, input logic b);
		@(posedge clock10);
		#1;
		knob_a = a;
		knob_b = b;
		repeat (HOLD) @(posedge clock10);
	endtask

	// clockwise: A leads B
	task automatic turn_knob(input int detents, input logic clockwise);
		int k;
		for (k = 0; k < detents; k++) begin
			if (clockwise) begin
				drive_knob_phase(1'b1, 1'b0);
				drive_knob_phase(1'b1, 1'b1);
				drive_knob_phase(1'b0, 1'b1);
				if (expected_offset < pulser_ctrl_pkg::OFFSET_MAX) expected_offset++;
			end else begin
				drive_knob_phase(1'b0, 1'b1);
				drive_knob_phase(1'b1, 1'b1);
				drive_knob_phase(1'b1, 1'b0);
				if (expected_offset > pulser_ctrl_pkg::OFFSET_MIN) expected_offset--;
			end
			drive_knob_phase(1'b0, 1'b0);
		end
		@(negedge clock10);
	endtask

	// push held past the debounce, then released past it again
	task automatic hold_recentre();
		@(posedge clock10);
		#1;
		knob_push = 1'b1;
		repeat (HOLD) @(posedge clock10);
		@(negedge clock10);
		expected_offset = 0;
		compare_offset(delay_offset, expected_offset, "offset while push held");
		@(posedge clock10);
		#1;
		knob_push = 1'b0;
		repeat (HOLD) @(posedge clock10);
		@(negedge clock10);
	endtask

	task automatic period_and_laser_pulse();
		int k;
		int high_cycles;
		high_cycles = 0;
		for (k = 0; k < PERIOD; k++) begin
			@(negedge clock10);
			if (laser_trigger !== 1'b0 || larpix_trigger !== 1'b0) high_cycles++;
		end
		compare_count(high_cycles, 0, "cycles with an output high before the first wrap");
		for (k = 0; k < 2; k++) begin
			measure_period();
			compare_count(period_len, PERIOD_CYCLES, "cycles between laser rises");
			compare_count(laser_high, LASER_WIDTH, "laser high time");
		end
	endtask

	task automatic default_readout_delays();
		check_readouts(TRIG1_DELAY, TRIG2_DELAY);
	endtask

	task automatic knob_steps();
		int n;
		n = lfsr_bits(4) + 1;
		turn_knob(n, 1'b1);
		wait_laser_rise();
		compare_offset(delay_offset, expected_offset, "offset after clockwise detents");
		check_readouts(TRIG1_DELAY + STEP * expected_offset, TRIG2_DELAY);
		n = lfsr_bits(4) + 1;
		turn_knob(n, 1'b0);
		wait_laser_rise();
		compare_offset(delay_offset, expected_offset, "offset after counter-clockwise detents");
		check_readouts(TRIG1_DELAY + STEP * expected_offset, TRIG2_DELAY);
	endtask

	task automatic offset_saturation_recentre();
		hold_recentre(); // start the climb from zero
		turn_knob(130, 1'b1);
		compare_offset(delay_offset, pulser_ctrl_pkg::OFFSET_MAX,
			"offset after 130 detents");
		hold_recentre();
		check_readouts(TRIG1_DELAY, TRIG2_DELAY);
	endtask

	task automatic rotary_switch_delays();
		int k;
		int value;
		for (k = 0; k < 4; k++) begin
			value = lfsr_bits(4);
			@(posedge clock10);
			#1;
			rot_n = ~pulser_ctrl_pkg::rot_t'(value); // switches are active low
			wait_laser_rise();
			check_readouts(TRIG1_DELAY + STEP * expected_offset, TRIG2_DELAY + STEP * value);
		end
	endtask

	task automatic cycle_counter_wrap();
		int k;
		logic rolled;
		pulser_timing_pkg::cycle_count_t last;
		rolled = 1'b0;
		last = cycle_count;
		for (k = 0; k < CYCLE_PERIODS; k++) begin
			wait_laser_rise();
			@(negedge clock10);
			compare_cycle(cycle_count, laser_rises, "cycle count against laser rises");
			if (last == 8'd255 && cycle_count == 8'd0) rolled = 1'b1;
			last = cycle_count;
		end
		if (!rolled) begin
			other_errors++;
			$display("cycle count never rolled over from 255 to 0");
		end
	endtask

	initial begin
		knob_a = 1'b0;
		knob_b = 1'b0;
		knob_push = 1'b0;
		rot_n = 4'hF;
		lfsr_state = 16'd16209;
		expected_offset = 0;
		wait (reset10 === 1'b1);
		wait (reset10 === 1'b0);
		period_and_laser_pulse();
		default_readout_delays();
		knob_steps();
		offset_saturation_recentre();
		rotary_switch_delays();
		cycle_counter_wrap();
		$display("errors: count %0d, offset %0d, cycle count %0d, other %0d",
			count_errors, offset_errors, cycle_errors, other_errors);
		if (count_errors + offset_errors + cycle_errors + other_errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: verif/pulser_tb_clock.sv
`timescale 1ns/1ps

module pulser_tb_clock #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 5
) (
	output logic clock10,
	output logic reset10
);

	initial begin
		clock10 = 1'b0;
		forever #(HALF_PERIOD) clock10 = ~clock10;
	end

	// release just after an edge, like every other input
	initial begin
		reset10 = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock10);
		#1;
		reset10 = 1'b0;
	end

endmodule

// File: verilog/laser_pulser_top.sv
`timescale 1ns/1ps

module laser_pulser_top #(
	parameter int PERIOD_COUNTS = pulser_timing_pkg::DEFAULT_PERIOD_COUNTS,
	parameter int LASER_WIDTH = pulser_timing_pkg::DEFAULT_LASER_WIDTH,
	parameter int TRIG1_DELAY = pulser_timing_pkg::DEFAULT_TRIG1_DELAY,
	parameter int TRIG2_DELAY = pulser_timing_pkg::DEFAULT_TRIG2_DELAY,
	parameter int TRIG_WIDTH = pulser_timing_pkg::DEFAULT_TRIG_WIDTH,
	parameter int STEP_COUNTS = pulser_timing_pkg::DEFAULT_STEP_COUNTS,
	parameter int DEBOUNCE_COUNTS = pulser_ctrl_pkg::DEFAULT_DEBOUNCE_COUNTS
) (
	input  logic clock10,
	input  logic reset10,
	input  logic knob_a,
	input  logic knob_b,
	input  logic knob_push,
	input  pulser_ctrl_pkg::rot_t rot_n,
	output logic laser_trigger,
	output logic larpix_trigger,
	output pulser_timing_pkg::cycle_count_t cycle_count,
	output pulser_ctrl_pkg::offset_t delay_offset
);

	logic knob_a_clean, knob_b_clean, knob_push_clean;
	logic step_up, step_down;
	logic wrap;
	logic trig1_pulse, trig2_pulse;
	pulser_timing_pkg::count_t position;
	pulser_timing_pkg::count_t trig1_delay, trig2_delay;
	pulser_timing_pkg::count_t laser_width, trig_width;

	assign laser_width = pulser_timing_pkg::count_t'(LASER_WIDTH);
	assign trig_width = pulser_timing_pkg::count_t'(TRIG_WIDTH);

	input_debounce #(.STABLE_COUNTS(DEBOUNCE_COUNTS)) i_debounce_a (
		.clock10(clock10), .reset10(reset10), .raw(knob_a), .clean(knob_a_clean));
	input_debounce #(.STABLE_COUNTS(DEBOUNCE_COUNTS)) i_debounce_b (
		.clock10(clock10), .reset10(reset10), .raw(knob_b), .clean(knob_b_clean));
	input_debounce #(.STABLE_COUNTS(DEBOUNCE_COUNTS)) i_debounce_push (
		.clock10(clock10), .reset10(reset10), .raw(knob_push), .clean(knob_push_clean));

	quadrature_decode i_quadrature_decode (
		.clock10(clock10), .reset10(reset10),
		.phase_a(knob_a_clean), .phase_b(knob_b_clean),
		.step_up(step_up), .step_down(step_down));

	delay_adjust #(
		.TRIG1_DELAY(TRIG1_DELAY), .TRIG2_DELAY(TRIG2_DELAY), .STEP_COUNTS(STEP_COUNTS)
	) i_delay_adjust (
		.clock10(clock10), .reset10(reset10),
		.step_up(step_up), .step_down(step_down), .recentre(knob_push_clean),
		.rot_n(rot_n), .trig1_delay(trig1_delay), .trig2_delay(trig2_delay),
		.delay_offset(delay_offset));

	period_sequencer #(.PERIOD_COUNTS(PERIOD_COUNTS)) i_period_sequencer (
		.clock10(clock10), .reset10(reset10),
		.position(position), .wrap(wrap), .cycle_count(cycle_count));

	// laser fires at the top of the period
	pulse_window #(.PERIOD_COUNTS(PERIOD_COUNTS)) i_window_laser (
		.clock10(clock10), .reset10(reset10), .position(position), .wrap(wrap),
		.delay('0), .width(laser_width), .pulse(laser_trigger));
	pulse_window #(.PERIOD_COUNTS(PERIOD_COUNTS)) i_window_trig1 (
		.clock10(clock10), .reset10(reset10), .position(position), .wrap(wrap),
		.delay(trig1_delay), .width(trig_width), .pulse(trig1_pulse));
	pulse_window #(.PERIOD_COUNTS(PERIOD_COUNTS)) i_window_trig2 (
		.clock10(clock10), .reset10(reset10), .position(position), .wrap(wrap),
		.delay(trig2_delay), .width(trig_width), .pulse(trig2_pulse));

	// both readout triggers share one output
	assign larpix_trigger = trig1_pulse | trig2_pulse;

endmodule

// File: verilog/pulse_window.sv
`timescale 1ns/1ps

module pulse_window #(
	parameter int PERIOD_COUNTS = pulser_timing_pkg::DEFAULT_PERIOD_COUNTS
) (
	input  logic clock10,
	input  logic reset10,
	input  pulser_timing_pkg::count_t position,
	input  logic wrap,
	input  pulser_timing_pkg::count_t delay,
	input  pulser_timing_pkg::count_t width,
	output logic pulse
);

	localparam pulser_timing_pkg::count_t PERIOD_LOAD =
		pulser_timing_pkg::count_t'(PERIOD_COUNTS);

	pulser_timing_pkg::count_t on_pos;
	pulser_timing_pkg::count_t off_pos;

	// all ones is above any position, nothing fires before the first wrap
	always_ff @(posedge clock10) begin
		if (reset10) begin
			on_pos <= '1;
			off_pos <= '1;
		end else if (wrap) begin
			on_pos <= PERIOD_LOAD - delay;
			off_pos <= PERIOD_LOAD - delay - width;
		end
	end

	// off wins if both match, so a zero width gives no pulse
	always_ff @(posedge clock10) begin
		if (reset10) begin
			pulse <= 1'b0;
		end else if (position == off_pos) begin
			pulse <= 1'b0;
		end else if (position == on_pos) begin
			pulse <= 1'b1;
		end
	end

endmodule

// File: verilog/period_sequencer.sv
`timescale 1ns/1ps

module period_sequencer #(
	parameter int PERIOD_COUNTS = pulser_timing_pkg::DEFAULT_PERIOD_COUNTS
) (
	input  logic clock10,
	input  logic reset10,
	output pulser_timing_pkg::count_t position,
	output logic wrap,
	output pulser_timing_pkg::cycle_count_t cycle_count
);

	localparam pulser_timing_pkg::count_t PERIOD_LOAD =
		pulser_timing_pkg::count_t'(PERIOD_COUNTS);

	// high for the one cycle at the bottom of the count
	assign wrap = (position == '0);

	// period is PERIOD_COUNTS + 1 cycles, 0 included
	always_ff @(posedge clock10) begin
		if (reset10) begin
			position <= PERIOD_LOAD;
		end else if (wrap) begin
			position <= PERIOD_LOAD;
		end else begin
			position <= position - 1'b1;
		end
	end

	// completed periods, rolls over at 255
	always_ff @(posedge clock10) begin
		if (reset10) begin
			cycle_count <= '0;
		end else if (wrap) begin
			cycle_count <= cycle_count + 1'b1;
		end
	end

endmodule

// File: verilog/delay_adjust.sv
`timescale 1ns/1ps

module delay_adjust #(
	parameter int TRIG1_DELAY = pulser_timing_pkg::DEFAULT_TRIG1_DELAY,
	parameter int TRIG2_DELAY = pulser_timing_pkg::DEFAULT_TRIG2_DELAY,
	parameter int STEP_COUNTS = pulser_timing_pkg::DEFAULT_STEP_COUNTS
) (
	input  logic clock10,
	input  logic reset10,
	input  logic step_up,
	input  logic step_down,
	input  logic recentre,
	input  pulser_ctrl_pkg::rot_t rot_n,
	output pulser_timing_pkg::count_t trig1_delay,
	output pulser_timing_pkg::count_t trig2_delay,
	output pulser_ctrl_pkg::offset_t delay_offset
);

	pulser_ctrl_pkg::offset_t offset;
	pulser_ctrl_pkg::rot_t rot_value;

	// saturating knob offset
	always_ff @(posedge clock10) begin
		if (reset10 || recentre) begin
			offset <= '0;
		end else if (step_up && !step_down) begin
			if (offset != pulser_ctrl_pkg::OFFSET_MAX) begin
				offset <= offset + 8'sd1;
			end
		end else if (step_down && !step_up) begin
			if (offset != pulser_ctrl_pkg::OFFSET_MIN) begin
				offset <= offset - 8'sd1;
			end
		end
	end

	// switches are active low
	always_ff @(posedge clock10) begin
		if (reset10) begin
			rot_value <= '0;
		end else begin
			rot_value <= ~rot_n;
		end
	end

	// offset sign extends, so negative steps pull the trigger earlier
	assign trig1_delay = pulser_timing_pkg::count_t'(TRIG1_DELAY + STEP_COUNTS * int'(offset));
	assign trig2_delay = pulser_timing_pkg::count_t'(TRIG2_DELAY
		+ STEP_COUNTS * int'(rot_value));

	assign delay_offset = offset;

endmodule

// File: verilog/quadrature_decode.sv
`timescale 1ns/1ps

module quadrature_decode (
	input  logic clock10,
	input  logic reset10,
	input  logic phase_a,
	input  logic phase_b,
	output logic step_up,
	output logic step_down
);

	logic [1:0] ab_prev; // {a, b} from last cycle
	logic a_rise;

	// one edge of A per detent
	assign a_rise = phase_a & ~ab_prev[1];

	always_ff @(posedge clock10) begin
		if (reset10) begin
			ab_prev <= '0;
		end else begin
			ab_prev <= {phase_a, phase_b};
		end
	end

	// B settles well before A moves, so the held value gives direction
	always_ff @(posedge clock10) begin
		if (reset10) begin
			step_up <= 1'b0;
			step_down <= 1'b0;
		end else begin
			step_up <= a_rise & ~ab_prev[0]; // clockwise
			step_down <= a_rise & ab_prev[0];
		end
	end

endmodule

// File: verilog/input_debounce.sv
`timescale 1ns/1ps

module input_debounce #(
	parameter int STABLE_COUNTS = pulser_ctrl_pkg::DEFAULT_DEBOUNCE_COUNTS
) (
	input  logic clock10,
	input  logic reset10,
	input  logic raw,
	output logic clean
);

	localparam pulser_ctrl_pkg::debounce_t STABLE_LIMIT =
		pulser_ctrl_pkg::debounce_t'(STABLE_COUNTS);

	logic [1:0] sync_q; // [1] is the synchronised level
	pulser_ctrl_pkg::debounce_t stable_count;

	always_ff @(posedge clock10) begin
		if (reset10) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[0], raw};
		end
	end

	// count how long the new level has held
	always_ff @(posedge clock10) begin
		if (reset10) begin
			stable_count <= '0;
			clean <= 1'b0;
		end else if (sync_q[1] == clean) begin
			stable_count <= '0; // bounced back, start over
		end else if (stable_count == STABLE_LIMIT) begin
			stable_count <= '0;
			clean <= sync_q[1];
		end else begin
			stable_count <= stable_count + 1'b1;
		end
	end

endmodule

// File: verilog/pulser_ctrl_pkg.sv
package pulser_ctrl_pkg;

	// knob offset, in delay steps
	typedef logic signed [7:0] offset_t;

	localparam offset_t OFFSET_MAX = 8'sd127;
	localparam offset_t OFFSET_MIN = -8'sd128;

	// rotary switch value after inversion
	typedef logic [3:0] rot_t;

	// stability count for mechanical inputs
	typedef logic [19:0] debounce_t;

	localparam int DEFAULT_DEBOUNCE_COUNTS = 100000; // 10 ms

endpackage

// File: verilog/pulser_timing_pkg.sv
package pulser_timing_pkg;

	// 24 bits covers one second at 10 MHz
	localparam int COUNT_WIDTH = 24;

	// position within a period, or a duration in clocks
	typedef logic [COUNT_WIDTH-1:0] count_t;

	// completed periods, free running
	typedef logic [7:0] cycle_count_t;

	// default timing in clock10 counts
	localparam int DEFAULT_PERIOD_COUNTS = 500000; // 20 Hz
	localparam int DEFAULT_LASER_WIDTH = 1000; // 100 us

	// readout triggers, delays from the laser rising edge
	localparam int DEFAULT_TRIG1_DELAY = 1760;
	localparam int DEFAULT_TRIG2_DELAY = 6750;
	localparam int DEFAULT_TRIG_WIDTH = 2; // 200 ns

	// one knob detent or one rotary switch step
	localparam int DEFAULT_STEP_COUNTS = 10; // 1 us

endpackage
